// ==== sim/mem_stimulus.txt ====
# slot port store addr wdata expect  (slot = cycle after reset, one request per port per slot)
# store is the one-hot code in binary, expect is x for writes
# aligned words on both ports at the same address
0 I 100 00000000 11223344 x
0 D 100 00000000 a5a5a5a5 x
1 I 000 00000000 00000000 11223344
1 D 000 00000000 00000000 a5a5a5a5
# misaligned words on imem, byte and halfword stores on dmem
2 I 100 00000030 eeeeeeee x
2 D 100 00000010 00000000 x
3 I 100 00000034 ffffffff x
3 D 100 00000014 99887766 x
4 I 100 00000031 d4c3b2a1 x
4 D 001 00000011 000000ab x
5 I 000 00000031 00000000 d4c3b2a1
5 D 001 00000013 000000cd x
6 I 000 00000030 00000000 c3b2a1ee
7 I 000 00000034 00000000 ffffffd4
7 D 010 00000012 0000beef x
8 I 100 00000040 00000000 x
8 D 010 00000010 00001234 x
9 I 100 00000044 00000000 x
9 D 010 00000013 00005a6b x
10 I 100 00000042 44332211 x
10 D 000 00000010 00000000 6bef1234
11 I 000 00000042 00000000 44332211
11 D 000 00000014 00000000 9988775a
12 I 000 00000040 00000000 22110000
12 D 100 00000020 00000000 x
13 I 000 00000044 00000000 00004433
13 D 001 00000022 00000077 x
14 I 100 00000050 12345678 x
14 D 010 00000021 0000c3d4 x
15 I 100 00000054 9abcdef0 x
15 D 001 00000020 00000099 x
16 I 100 00000053 0d0c0b0a x
16 D 000 00000020 00000000 00c3d499
# back-to-back reads on imem, bank wrap on dmem
17 I 000 00000053 00000000 0d0c0b0a
17 D 100 00001ffc 76543210 x
18 I 000 00000050 00000000 0a345678
18 D 100 00001ffe 0fedcba9 x
19 I 000 00000054 00000000 9a0d0c0b
19 D 000 00001ffe 00000000 0fedcba9
20 D 000 00001ffc 00000000 cba93210
21 D 000 00000000 00000000 a5a50fed

// ==== mem_interface.f ====
common/mem_geom_pkg.sv
common/mem_req_pkg.sv
mem_port/byte_bank.sv
mem_port/lane_steer.sv
mem_port/mem_port.sv
hdl/mem_interface.sv
sim/mem_port_props.sv
sim/mem_checker.sv
sim/tb_mem_interface.sv

// ==== Makefile ====
TOP := tb_mem_interface
SRCS := $(filter-out +%,$(shell cat mem_interface.f))

.PHONY: all run clean

all: run

obj_dir/V$(TOP): mem_interface.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mem_interface.f

# pass only when the testbench prints its pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf obj_dir

// ==== sim/tb_mem_interface.sv ====
`timescale 1ns/10ps

module tb_mem_interface;

    import mem_geom_pkg::*;
    import mem_req_pkg::*;

    // one request line of the stimulus file
    typedef struct packed {
        int slot;
        logic dmem;
        logic check;
        mem_req_t req;
        logic [31:0] exp_word;
    } stim_entry_t;

    logic clk_1;
    logic rst_n_sync;
    mem_req_t imem_req;
    mem_req_t dmem_req;
    mem_word_u imem_rdata;
    mem_word_u dmem_rdata;

    // expected read words, presented one cycle after their strobe
    logic imem_exp_valid;
    logic [31:0] imem_exp_word;
    logic dmem_exp_valid;
    logic [31:0] dmem_exp_word;

    int check_count;
    int error_count;
    int file_errors;
    logic lines_loaded;
    stim_entry_t entries[$];

    // wrap addresses in the stimulus assume 2048 words per bank
    mem_interface #(
        .bank_addr_w(11)
    ) i_dut (
        .clk_1(clk_1),
        .rst_n_sync(rst_n_sync),
        .imem_req(imem_req),
        .dmem_req(dmem_req),
        .imem_rdata(imem_rdata),
        .dmem_rdata(dmem_rdata)
    );

    mem_checker i_checker (
        .clk_1(clk_1),
        .rst_n_sync(rst_n_sync),
        .imem_req(imem_req),
        .dmem_req(dmem_req),
        .imem_rdata(imem_rdata),
        .dmem_rdata(dmem_rdata),
        .imem_exp_valid(imem_exp_valid),
        .imem_exp_word(imem_exp_word),
        .dmem_exp_valid(dmem_exp_valid),
        .dmem_exp_word(dmem_exp_word),
        .check_count(check_count),
        .error_count(error_count)
    );

    initial begin
        clk_1 = 1'b0;
        forever #4 clk_1 = ~clk_1;
    end

    // columns: slot, port letter, store code, address, write data, expected word
    task automatic load_stimulus(input int fd);
        string tok;
        string port_s;
        string exp_s;
        logic [2:0] code;
        logic [31:0] addr;
        logic [31:0] wdata;
        stim_entry_t entry;
        int ch;

        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
                // skip to the newline
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if ($fscanf(fd, "%s %b %h %h %s", port_s, code, addr, wdata, exp_s) != 5) begin
                $display("stimulus line at slot %s is incomplete", tok);
                file_errors++;
            end else begin
                if (port_s != "I" && port_s != "D") begin
                    $display("unknown port letter %s at stimulus slot %s", port_s, tok);
                    file_errors++;
                end
                entry.slot = tok.atoi();
                entry.dmem = (port_s == "D");
                entry.req.en = 1'b1;
                entry.req.store = store_size_e'(code);
                entry.req.addr = addr;
                entry.req.wdata.word = wdata;
                // anything but a one-hot size is a read
                entry.check = !(code inside {3'b001, 3'b010, 3'b100}) && exp_s != "x";
                entry.exp_word = exp_s.atohex();
                entries.push_back(entry);
            end
        end
    endtask

    initial begin
        int fd;
        int idx;
        int last_slot;
        logic imem_pend;
        logic dmem_pend;
        logic [31:0] imem_pend_word;
        logic [31:0] dmem_pend_word;

        rst_n_sync = 1'b0;
        imem_req = '0;
        dmem_req = '0;
        imem_exp_valid = 1'b0;
        imem_exp_word = '0;
        dmem_exp_valid = 1'b0;
        dmem_exp_word = '0;
        file_errors = 0;
        lines_loaded = 1'b0;
        fd = $fopen("sim/mem_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file sim/mem_stimulus.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            load_stimulus(fd);
            $fclose(fd);
            if (entries.size() == 0) begin
                $display("the stimulus file holds no requests");
                file_errors++;
            end
            lines_loaded = 1'b1;
            repeat (8) @(posedge clk_1);
            rst_n_sync <= 1'b1;
            @(posedge clk_1);
            last_slot = (entries.size() > 0) ? entries[entries.size() - 1].slot : -1;
            idx = 0;
            imem_pend = 1'b0;
            dmem_pend = 1'b0;
            imem_pend_word = '0;
            dmem_pend_word = '0;
            // two extra slots flush the last expected words
            for (int s = 0; s <= last_slot + 2; s++) begin
                @(posedge clk_1);
                imem_exp_valid <= imem_pend;
                imem_exp_word <= imem_pend_word;
                dmem_exp_valid <= dmem_pend;
                dmem_exp_word <= dmem_pend_word;
                imem_pend = 1'b0;
                dmem_pend = 1'b0;
                imem_req <= '0;
                dmem_req <= '0;
                while (idx < entries.size() && entries[idx].slot == s) begin
                    if (entries[idx].dmem) begin
                        dmem_req <= entries[idx].req;
                        dmem_pend = entries[idx].check;
                        dmem_pend_word = entries[idx].exp_word;
                    end else begin
                        imem_req <= entries[idx].req;
                        imem_pend = entries[idx].check;
                        imem_pend_word = entries[idx].exp_word;
                    end
                    idx++;
                end
            end
            repeat (3) @(posedge clk_1);
            if (idx != entries.size()) begin
                $display("%0d stimulus lines were never driven, slots must not decrease",
                         entries.size() - idx);
                file_errors++;
            end
            $display("checks: %0d, errors: %0d", check_count, error_count + file_errors);
            if (error_count + file_errors == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    // watchdog scaled to the number of requests
    initial begin
        int limit_ns;

        wait (lines_loaded);
        limit_ns = (8 + 3 * entries.size() + 20) * 8;
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== sim/mem_checker.sv ====
`timescale 1ns/10ps

module mem_checker (
    input  logic clk_1,
    input  logic rst_n_sync,
    input  mem_req_pkg::mem_req_t imem_req,
    input  mem_req_pkg::mem_req_t dmem_req,
    input  mem_geom_pkg::mem_word_u imem_rdata,
    input  mem_geom_pkg::mem_word_u dmem_rdata,
    input  logic imem_exp_valid,
    input  logic [31:0] imem_exp_word,
    input  logic dmem_exp_valid,
    input  logic [31:0] dmem_exp_word,
    output int check_count,
    output int error_count
);

    import mem_req_pkg::*;

    // a read whose data sits on rdata during the current cycle
    typedef struct packed {
        logic due;
        logic strobed;
        logic [31:0] addr;
        logic [31:0] word;
    } pending_t;

    // read strobe and address taken by the DUT at the last edge
    logic imem_rd_q;
    logic dmem_rd_q;
    logic [31:0] imem_addr_q;
    logic [31:0] dmem_addr_q;

    pending_t imem_pend;
    pending_t dmem_pend;

    int checks = 0;
    int errors = 0;

    assign check_count = checks;
    assign error_count = errors;

    // only the three one-hot codes store
    function automatic logic is_read(input mem_req_t req);
        return req.en && !(req.store inside {store_byte, store_half, store_word});
    endfunction

    task automatic compare_read(input string port, input pending_t pend, input logic [31:0] got);
        checks++;
        if (!pend.strobed) begin
            errors++;
            $display("%s: an expected word came at %0t ns with no read strobed before it",
                     port, $time);
        end else if (got !== pend.word) begin
            errors++;
            $display("[FAIL] %0t ns %s read at %h gave %h, expected %h",
                     $time, port, pend.addr, got, pend.word);
        end
    endtask

    always @(posedge clk_1 or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            imem_rd_q <= 1'b0;
            dmem_rd_q <= 1'b0;
        end else begin
            imem_rd_q <= is_read(imem_req);
            dmem_rd_q <= is_read(dmem_req);
            imem_addr_q <= imem_req.addr;
            dmem_addr_q <= dmem_req.addr;
        end
    end

    // expected word and strobe that belong to the current rdata
    assign imem_pend = '{imem_exp_valid, imem_rd_q, imem_addr_q, imem_exp_word};
    assign dmem_pend = '{dmem_exp_valid, dmem_rd_q, dmem_addr_q, dmem_exp_word};

    // rdata settles after the rising edge and is compared mid cycle
    always @(negedge clk_1) begin
        if (imem_pend.due) begin
            compare_read("imem", imem_pend, imem_rdata.word);
        end
        if (dmem_pend.due) begin
            compare_read("dmem", dmem_pend, dmem_rdata.word);
        end
    end

endmodule

// ==== sim/mem_port_props.sv ====
`timescale 1ns/10ps

module mem_port_props (
    input logic clk_1,
    input logic rst_n_sync,
    input mem_req_pkg::mem_req_t req,
    input mem_geom_pkg::mem_word_u rdata,
    input mem_geom_pkg::lane_sel_t last_offset,
    input mem_geom_pkg::lane_mask_t lane_we
);

    import mem_req_pkg::*;

    logic rd_strobe;

    assign rd_strobe = req.en && !(req.store inside {store_byte, store_half, store_word});

    // holds for reads of bytes that were written earlier
    a_rdata_known: assert property (@(posedge clk_1) disable iff (!rst_n_sync)
        $past(rd_strobe) |-> !$isunknown(rdata))
        else $error("rdata has unknown bits one cycle after a read");

    a_offset_on_en: assert property (@(posedge clk_1) disable iff (!rst_n_sync)
        !$past(req.en) |-> $stable(last_offset))
        else $error("offset register changed in a cycle without a request");

    a_no_write_on_read: assert property (@(posedge clk_1) disable iff (!rst_n_sync)
        (req.store == store_none) |-> (lane_we == '0))
        else $error("write mask is set for a read request");

endmodule

bind mem_port mem_port_props i_mem_port_props (
    .clk_1(clk_1),
    .rst_n_sync(rst_n_sync),
    .req(req),
    .rdata(rdata),
    .last_offset(last_offset),
    .lane_we(lane_we)
);

// ==== hdl/mem_interface.sv ====
`timescale 1ns/10ps

module mem_interface #(
    // index width of every byte bank, 11 gives 2 KB per lane
    parameter int bank_addr_w = 11
) (
    input  logic clk_1,
    input  logic rst_n_sync,
    input  mem_req_pkg::mem_req_t imem_req,
    input  mem_req_pkg::mem_req_t dmem_req,
    output mem_geom_pkg::mem_word_u imem_rdata,
    output mem_geom_pkg::mem_word_u dmem_rdata
);

    // instruction side
    mem_port #(
        .bank_addr_w(bank_addr_w)
    ) i_imem (
        .clk_1(clk_1),
        .rst_n_sync(rst_n_sync),
        .req(imem_req),
        .rdata(imem_rdata)
    );

    // data side, fully separate storage
    // same byte address on both ports refers to different memory
    mem_port #(
        .bank_addr_w(bank_addr_w)
    ) i_dmem (
        .clk_1(clk_1),
        .rst_n_sync(rst_n_sync),
        .req(dmem_req),
        .rdata(dmem_rdata)
    );

endmodule

// ==== mem_port/mem_port.sv ====
`timescale 1ns/10ps

module mem_port #(
    parameter int bank_addr_w = 11
) (
    input  logic clk_1,
    input  logic rst_n_sync,
    input  mem_req_pkg::mem_req_t req,
    output mem_geom_pkg::mem_word_u rdata
);

    import mem_geom_pkg::*;

    // steered request, one entry per lane
    logic [n_lanes-1:0][bank_addr_w-1:0] lane_index;
    byte_t [n_lanes-1:0] lane_wdata;
    lane_mask_t lane_we;

    // raw bank outputs, still in lane order
    byte_t [n_lanes-1:0] bank_rdata;

    // byte offset of the access that produced bank_rdata
    lane_sel_t last_offset;

    lane_steer #(
        .bank_addr_w(bank_addr_w)
    ) i_lane_steer (
        .req(req),
        .lane_index(lane_index),
        .lane_wdata(lane_wdata),
        .lane_we(lane_we)
    );

    // four byte banks, all enabled by the request strobe
    for (genvar l = 0; l < n_lanes; l++) begin : g_bank
        byte_bank #(
            .bank_addr_w(bank_addr_w)
        ) i_byte_bank (
            .clk_1(clk_1),
            .en(req.en),
            .we(lane_we[l]),
            .index(lane_index[l]),
            .wdata(lane_wdata[l]),
            .rdata(bank_rdata[l])
        );
    end

    // offset travels alongside the bank read, one cycle behind the strobe
    always_ff @(posedge clk_1 or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            last_offset <= '0;
        end else if (req.en) begin
            last_offset <= req.addr[1:0];
        end
    end

    // realign a misaligned read
    // byte k of rdata comes from lane (offset + k) mod 4
    always_comb begin
        lane_sel_t src;

        for (int k = 0; k < n_lanes; k++) begin
            src = lane_sel_t'(k) + last_offset;
            rdata.lanes[k] = bank_rdata[src];
        end
    end

endmodule

// ==== mem_port/lane_steer.sv ====
`timescale 1ns/10ps

module lane_steer #(
    parameter int bank_addr_w = 11
) (
    input  mem_req_pkg::mem_req_t req,
    output logic [mem_geom_pkg::n_lanes-1:0][bank_addr_w-1:0] lane_index,
    output mem_geom_pkg::byte_t [mem_geom_pkg::n_lanes-1:0] lane_wdata,
    output mem_geom_pkg::lane_mask_t lane_we
);

    import mem_geom_pkg::*;
    import mem_req_pkg::*;

    logic [bank_addr_w-1:0] index_base;
    logic [bank_addr_w-1:0] index_next;
    lane_sel_t offset;
    lane_mask_t size_mask;

    // word index and byte offset of the first addressed byte
    // address bits above the bank depth alias
    assign index_base = req.addr[bank_addr_w+1:2];
    assign offset = req.addr[1:0];

    // wraps to index 0 at the top of the bank
    assign index_next = index_base + 1'b1;

    // mask for a store that starts at lane 0
    always_comb begin
        case (req.store)
            store_byte: begin
                size_mask = 4'b0001;
            end
            store_half: begin
                size_mask = 4'b0011;
            end
            store_word: begin
                size_mask = 4'b1111;
            end
            default: begin
                size_mask = '0;
            end
        endcase
    end

    // per lane steering
    // lane l carries byte (l - offset) mod 4 of the request
    for (genvar l = 0; l < n_lanes; l++) begin : g_lane
        lane_sel_t src;

        assign src = lane_sel_t'(l) - offset;

        // lanes below the offset hold the spill into the next word
        assign lane_index[l] = (lane_sel_t'(l) < offset) ? index_next : index_base;

        assign lane_wdata[l] = req.wdata.lanes[src];

        // rotating the mask this way also wraps a halfword from lane 3 to lane 0
        assign lane_we[l] = size_mask[src];
    end

endmodule

// ==== mem_port/byte_bank.sv ====
`timescale 1ns/10ps

module byte_bank #(
    parameter int bank_addr_w = 11
) (
    input  logic clk_1,
    input  logic en,
    input  logic we,
    input  logic [bank_addr_w-1:0] index,
    input  mem_geom_pkg::byte_t wdata,
    output mem_geom_pkg::byte_t rdata
);

    import mem_geom_pkg::*;

    localparam int depth = 2 ** bank_addr_w;

    // storage for one byte lane
    byte_t mem [depth];

    // synchronous single port access
    // a write leaves rdata at its previous value
    always_ff @(posedge clk_1) begin
        if (en) begin
            if (we) begin
                mem[index] <= wdata;
            end else begin
                rdata <= mem[index];
            end
        end
    end

endmodule

// ==== common/mem_req_pkg.sv ====
package mem_req_pkg;

    // byte address width seen by the core
    localparam int addr_w = 32;

    // one-hot store control from the core
    // codes outside this set are treated as a read
    typedef enum logic [2:0] {
        store_none = 3'b000,
        store_byte = 3'b001,
        store_half = 3'b010,
        store_word = 3'b100
    } store_size_e;

    // one request on a port
    // en is a single-cycle strobe, no back-pressure
    // store_none means read, anything else writes the low bytes of wdata
    typedef struct packed {
        logic en;
        store_size_e store;
        logic [addr_w-1:0] addr;
        mem_geom_pkg::mem_word_u wdata;
    } mem_req_t;

endpackage

// ==== common/mem_geom_pkg.sv ====
package mem_geom_pkg;

    // byte lanes that make up one memory word
    localparam int n_lanes = 4;
    localparam int byte_w = 8;
    localparam int word_w = n_lanes * byte_w;

    // bits needed to pick a lane out of a word
    localparam int lane_sel_w = $clog2(n_lanes);

    // data held by a single lane
    typedef logic [byte_w-1:0] byte_t;

    // byte offset within a word
    typedef logic [lane_sel_w-1:0] lane_sel_t;

    // one write enable per lane
    typedef logic [n_lanes-1:0] lane_mask_t;

    // one data word, read whole or as separate lanes
    // lane 0 is the least significant byte
    typedef union packed {
        logic [word_w-1:0] word;
        byte_t [n_lanes-1:0] lanes;
    } mem_word_u;

endpackage
